//--- hdl/mvp_seq_config.svh
`ifndef MVP_SEQ_CONFIG_SVH
`define MVP_SEQ_CONFIG_SVH

// pipeline shape
`define MVP_NUM_STAGES        10
`define MVP_FIRST_LEVEL_STAGE 5

// level numbering, levels run 1 to 12 with 0 for an empty slot
`define MVP_LEVEL_WIDTH       4
`define MVP_MAX_LEVEL         12

`define MVP_SETTLE_CYCLES     3
`define MVP_CNT_WIDTH         16

`endif

//--- hdl/mvp_seq_pkg.sv
`default_nettype none

`include "mvp_seq_config.svh"

package mvp_seq_pkg;

    // one bit per stage, used for activity, starts and dones
    typedef logic [`MVP_NUM_STAGES-1:0] stage_mask_t;

    // level number carried by the back stages
    typedef logic [`MVP_LEVEL_WIDTH-1:0] level_t;

    // rounds issued since the job start
    typedef logic [`MVP_CNT_WIDTH-1:0] round_cnt_t;

endpackage

`default_nettype wire

//--- hdl/mvp_round_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvp_seq_config.svh"

module mvp_round_ctrl
(
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       i_mvp_start,
    input  wire                       i_enable,
    input  mvp_seq_pkg::stage_mask_t  i_stage_done,
    input  mvp_seq_pkg::stage_mask_t  i_active,
    input  wire                       i_job_done,
    output logic                      o_job_start,
    output logic                      o_round_end,
    output logic                      o_start_pulse,
    output logic                      o_mvp_idle,
    output mvp_seq_pkg::round_cnt_t   o_stage_cnt
);

    import mvp_seq_pkg::*;

    localparam int SETTLE_W = $clog2(`MVP_SETTLE_CYCLES + 1);

    logic [SETTLE_W-1:0] settle_cnt;
    stage_mask_t         stage_ready;
    round_cnt_t          round_cnt;

    // a start only counts while enabled
    assign o_job_start = i_mvp_start & i_enable;

    // inactive stages never hold up a round
    assign stage_ready = i_stage_done | ~i_active;

    assign o_round_end = (settle_cnt == SETTLE_W'(`MVP_SETTLE_CYCLES)) & (&stage_ready);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            o_mvp_idle <= 1'b1;
        else if (o_job_start)
            o_mvp_idle <= 1'b0;
        else if (i_job_done)
            o_mvp_idle <= 1'b1;
    end

    // minimum spacing between round ends
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            settle_cnt <= '0;
        else if (o_round_end)
            settle_cnt <= '0;
        else if (settle_cnt < SETTLE_W'(`MVP_SETTLE_CYCLES))
            settle_cnt <= settle_cnt + 1'b1;
    end

    // starts go out one cycle after the round closes
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            o_start_pulse <= 1'b0;
        else
            o_start_pulse <= o_round_end & ~o_mvp_idle;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            round_cnt <= '0;
        else if (o_job_start)
            round_cnt <= '0;
        else if (o_start_pulse)
            round_cnt <= round_cnt + 1'b1;
    end

    assign o_stage_cnt = round_cnt;

endmodule

`default_nettype wire

//--- hdl/mvp_stage_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvp_seq_config.svh"

module mvp_stage_tracker
(
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       i_job_start,
    input  wire                       i_round_end,
    input  wire                       i_start_pulse,
    input  wire                       i_feed_alldone,
    input  wire                       i_reduce_trace,
    input  mvp_seq_pkg::level_t       i_s8_level,
    output mvp_seq_pkg::stage_mask_t  o_active,
    output logic                      o_s5_next_active,
    output mvp_seq_pkg::stage_mask_t  o_stage_start,
    output logic                      o_switch_mode
);

    import mvp_seq_pkg::*;

    localparam int NS = `MVP_NUM_STAGES;
    localparam int S5 = `MVP_FIRST_LEVEL_STAGE;
    localparam int S8 = `MVP_NUM_STAGES - 2;

    stage_mask_t active_r;
    stage_mask_t active_nxt;
    logic        s5_src;
    logic        below_max;

    // stage 5 loops back from stage 8 once reduce trace is on
    assign s5_src    = i_reduce_trace ? active_r[S8] : active_r[S5-1];
    assign below_max = i_s8_level < level_t'(`MVP_MAX_LEVEL);

    assign o_s5_next_active = s5_src & below_max;

    always_comb
    begin
        active_nxt     = {active_r[NS-2:0], ~i_feed_alldone};
        active_nxt[S5] = o_s5_next_active;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            active_r <= '0;
        else if (i_job_start)
            active_r <= '0;
        else if (i_round_end)
            active_r <= active_nxt;
    end

    assign o_active = active_r;

    assign o_stage_start = {NS{i_start_pulse}} & active_r;

    // back half busy
    assign o_switch_mode = i_start_pulse & (|active_r[NS-1:S5]);

endmodule

`default_nettype wire

//--- hdl/mvp_level_pipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvp_seq_config.svh"

module mvp_level_pipe
(
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  i_job_start,
    input  wire                  i_round_end,
    input  wire                  i_skip_trace,
    input  mvp_seq_pkg::level_t  i_reduce_level,
    input  wire                  i_s5_next_active,
    input  wire                  i_s9_active,
    input  wire                  i_idle,
    output mvp_seq_pkg::level_t  o_s8_level,
    output logic                 o_reduce_trace,
    output logic                 o_mvp_done,
    output logic                 o_last_write,
    output mvp_seq_pkg::level_t  o_mux_level,
    output mvp_seq_pkg::level_t  o_mulacc_level,
    output mvp_seq_pkg::level_t  o_addx_level,
    output mvp_seq_pkg::level_t  o_uram_index
);

    import mvp_seq_pkg::*;

    localparam int S5 = `MVP_FIRST_LEVEL_STAGE;
    localparam int S7 = `MVP_FIRST_LEVEL_STAGE + 2;
    localparam int S8 = `MVP_NUM_STAGES - 2;
    localparam int S9 = `MVP_NUM_STAGES - 1;

    level_t lvl_r [S5:S9];
    level_t s5_lvl_nxt;
    logic   reduce_trace_r;

    // fresh work enters at level 1, traced work goes one level up
    assign s5_lvl_nxt = !i_s5_next_active ? '0 :
                        (reduce_trace_r ? level_t'(lvl_r[S8] + 1'b1) : level_t'(1));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int k = S5; k <= S9; k++)
                lvl_r[k] <= '0;
        end
        else if (i_job_start)
        begin
            for (int k = S5; k <= S9; k++)
                lvl_r[k] <= '0;
        end
        else if (i_round_end)
        begin
            lvl_r[S5] <= s5_lvl_nxt;
            for (int k = S5 + 1; k <= S9; k++)
                lvl_r[k] <= lvl_r[k-1];
        end
    end

    // sticky until the next job
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            reduce_trace_r <= 1'b0;
        else if (i_job_start)
            reduce_trace_r <= 1'b0;
        else if ((lvl_r[S8] == i_reduce_level) && !i_skip_trace)
            reduce_trace_r <= 1'b1;
    end

    assign o_reduce_trace = reduce_trace_r;
    assign o_s8_level     = lvl_r[S8];

    assign o_last_write = (lvl_r[S9] == level_t'(`MVP_MAX_LEVEL)) ||
                          (i_skip_trace && (lvl_r[S9] == i_reduce_level));

    assign o_mvp_done = o_last_write & i_s9_active & i_round_end;

    // map stage levels to the indices the level-dependent units expect
    assign o_mux_level = (lvl_r[S5] > i_reduce_level) ?
                         level_t'(`MVP_MAX_LEVEL + 1 + i_reduce_level - lvl_r[S5]) : lvl_r[S5];

    assign o_mulacc_level = (lvl_r[S7] > i_reduce_level) ?
                            level_t'(`MVP_MAX_LEVEL + i_reduce_level - lvl_r[S7]) :
                            level_t'(lvl_r[S7] - 1'b1);

    assign o_addx_level = (lvl_r[S9] >= i_reduce_level) ? '0 : lvl_r[S5];

    assign o_uram_index = (reduce_trace_r || i_idle) ? '0 : level_t'(lvl_r[S9] - 1'b1);

endmodule

`default_nettype wire

//--- hdl/mvp_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvp_seq_config.svh"

module mvp_controller
(
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       i_mvp_start,
    input  wire                       i_enable,
    input  wire                       i_skip_trace,
    input  mvp_seq_pkg::level_t       i_reduce_level,
    input  mvp_seq_pkg::stage_mask_t  i_stage_done,
    input  wire                       i_feed_alldone,
    output mvp_seq_pkg::stage_mask_t  o_stage_start,
    output logic                      o_mvp_done,
    output logic                      o_mvp_idle,
    output mvp_seq_pkg::round_cnt_t   o_stage_cnt,
    output logic                      o_reduce_trace,
    output logic                      o_switch_mode,
    output logic                      o_last_write,
    output mvp_seq_pkg::level_t       o_mux_level,
    output mvp_seq_pkg::level_t       o_mulacc_level,
    output mvp_seq_pkg::level_t       o_addx_level,
    output mvp_seq_pkg::level_t       o_uram_index
);

    import mvp_seq_pkg::*;

    logic        job_start;
    logic        round_end;
    logic        start_pulse;
    logic        s5_next_active;
    stage_mask_t active;
    level_t      s8_level;

    mvp_round_ctrl u_round_ctrl
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_mvp_start   (i_mvp_start),
        .i_enable      (i_enable),
        .i_stage_done  (i_stage_done),
        .i_active      (active),
        .i_job_done    (o_mvp_done),
        .o_job_start   (job_start),
        .o_round_end   (round_end),
        .o_start_pulse (start_pulse),
        .o_mvp_idle    (o_mvp_idle),
        .o_stage_cnt   (o_stage_cnt)
    );

    mvp_stage_tracker u_stage_tracker
    (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_job_start      (job_start),
        .i_round_end      (round_end),
        .i_start_pulse    (start_pulse),
        .i_feed_alldone   (i_feed_alldone),
        .i_reduce_trace   (o_reduce_trace),
        .i_s8_level       (s8_level),
        .o_active         (active),
        .o_s5_next_active (s5_next_active),
        .o_stage_start    (o_stage_start),
        .o_switch_mode    (o_switch_mode)
    );

    // stage 9 activity decides whether a finished level ends the job
    mvp_level_pipe u_level_pipe
    (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_job_start      (job_start),
        .i_round_end      (round_end),
        .i_skip_trace     (i_skip_trace),
        .i_reduce_level   (i_reduce_level),
        .i_s5_next_active (s5_next_active),
        .i_s9_active      (active[`MVP_NUM_STAGES-1]),
        .i_idle           (o_mvp_idle),
        .o_s8_level       (s8_level),
        .o_reduce_trace   (o_reduce_trace),
        .o_mvp_done       (o_mvp_done),
        .o_last_write     (o_last_write),
        .o_mux_level      (o_mux_level),
        .o_mulacc_level   (o_mulacc_level),
        .o_addx_level     (o_addx_level),
        .o_uram_index     (o_uram_index)
    );

endmodule

`default_nettype wire

//--- verif/mvp_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvp_seq_config.svh"

module mvp_checker
(
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       i_mvp_start,
    input  wire                       i_enable,
    input  wire                       i_skip_trace,
    input  mvp_seq_pkg::level_t       i_reduce_level,
    input  mvp_seq_pkg::stage_mask_t  i_stage_done,
    input  wire                       i_feed_alldone,
    input  mvp_seq_pkg::stage_mask_t  i_stage_start,
    input  wire                       i_mvp_done,
    input  wire                       i_mvp_idle,
    input  mvp_seq_pkg::round_cnt_t   i_stage_cnt,
    input  wire                       i_reduce_trace,
    input  wire                       i_switch_mode,
    input  wire                       i_last_write,
    input  mvp_seq_pkg::level_t       i_mux_level,
    input  mvp_seq_pkg::level_t       i_mulacc_level,
    input  mvp_seq_pkg::level_t       i_addx_level,
    input  mvp_seq_pkg::level_t       i_uram_index,
    output int                        o_error_count
);

    import mvp_seq_pkg::*;

    localparam int NS   = `MVP_NUM_STAGES;
    localparam int MAXL = `MVP_MAX_LEVEL;

    // cycle model of the sequencer
    logic        m_idle;
    int          m_settle;
    logic        m_pulse;
    round_cnt_t  m_cnt;
    stage_mask_t m_active;
    level_t      m_lvl [5:9];
    logic        m_trace;
    int          check_count = 0;
    int          error_count = 0;

    assign o_error_count = error_count;

    task automatic reset_model();
        m_idle   = 1'b1;
        m_settle = 0;
        m_pulse  = 1'b0;
        m_cnt    = '0;
        m_active = '0;
        m_trace  = 1'b0;
        for (int k = 5; k <= 9; k++)
            m_lvl[k] = '0;
    endtask

    task automatic expect_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        check_count++;
        if (act !== exp)
        begin
            error_count++;
            $display("ERROR at %0t: %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    task automatic print_counts();
        $display("checks: %0d, errors: %0d", check_count, error_count);
    endtask

    always @(negedge clk)
    begin : model_step
        logic        job_start;
        logic        rend;
        logic        lw;
        logic        done_exp;
        logic        s5_next;
        int          rl;
        int          l5;
        int          l7;
        int          l8;
        int          l9;

        if (!rst_n)
            reset_model();
        rl = i_reduce_level;
        l5 = m_lvl[5];
        l7 = m_lvl[7];
        l8 = m_lvl[8];
        l9 = m_lvl[9];
        job_start = i_mvp_start & i_enable;
        // a round closes once settled and no active stage is busy
        rend     = (m_settle == 3) && ((m_active & ~i_stage_done) == '0);
        lw       = (l9 == MAXL) || (i_skip_trace && (l9 == rl));
        done_exp = lw && m_active[NS-1] && rend;

        expect_value("o_stage_start", m_pulse ? m_active : '0, i_stage_start);
        expect_value("o_mvp_done", done_exp, i_mvp_done);
        expect_value("o_mvp_idle", m_idle, i_mvp_idle);
        expect_value("o_stage_cnt", m_cnt, i_stage_cnt);
        expect_value("o_reduce_trace", m_trace, i_reduce_trace);
        expect_value("o_switch_mode", m_pulse && (m_active[NS-1:5] != '0), i_switch_mode);
        expect_value("o_last_write", lw, i_last_write);
        expect_value("o_mux_level", ((l5 > rl) ? (MAXL + 1 + rl - l5) : l5) & 15, i_mux_level);
        expect_value("o_mulacc_level", ((l7 > rl) ? (MAXL + rl - l7) : (l7 - 1)) & 15,
                     i_mulacc_level);
        expect_value("o_addx_level", (l9 >= rl) ? 0 : l5, i_addx_level);
        expect_value("o_uram_index", (m_trace || m_idle) ? 0 : ((l9 - 1) & 15), i_uram_index);

        if (rst_n)
        begin
            s5_next = (m_trace ? m_active[8] : m_active[4]) && (l8 < MAXL);
            if (job_start)
            begin
                m_active = '0;
                for (int k = 5; k <= 9; k++)
                    m_lvl[k] = '0;
            end
            else if (rend)
            begin
                m_active    = {m_active[NS-2:0], ~i_feed_alldone};
                m_active[5] = s5_next;
                for (int k = 9; k > 5; k--)
                    m_lvl[k] = m_lvl[k-1];
                m_lvl[5] = !s5_next ? level_t'(0) : (m_trace ? level_t'(l8 + 1) : level_t'(1));
            end
            m_cnt    = job_start ? '0 : (m_pulse ? m_cnt + 1'b1 : m_cnt);
            m_pulse  = rend && !m_idle;
            m_settle = rend ? 0 : ((m_settle < 3) ? m_settle + 1 : m_settle);
            m_idle   = job_start ? 1'b0 : (done_exp ? 1'b1 : m_idle);
            m_trace  = job_start ? 1'b0 : (((l8 == rl) && !i_skip_trace) ? 1'b1 : m_trace);
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_mvp_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvp_seq_config.svh"

module tb_mvp_controller;

    import mvp_seq_pkg::*;

    localparam int NS          = `MVP_NUM_STAGES;
    localparam int NUM_JOBS    = 20;
    localparam int ROUND_LIMIT = 150;
    // a round never takes more than 8 cycles
    localparam int CYCLE_LIMIT = ROUND_LIMIT * 8;
    // jobs x rounds per job x cycles per round x clock period
    localparam int WATCHDOG_NS = NUM_JOBS * 200 * 8 * 40;

    logic        clk;
    logic        rst_n;
    logic        i_mvp_start;
    logic        i_enable;
    logic        i_skip_trace;
    level_t      i_reduce_level;
    stage_mask_t i_stage_done;
    logic        i_feed_alldone;
    stage_mask_t o_stage_start;
    logic        o_mvp_done;
    logic        o_mvp_idle;
    round_cnt_t  o_stage_cnt;
    logic        o_reduce_trace;
    logic        o_switch_mode;
    logic        o_last_write;
    level_t      o_mux_level;
    level_t      o_mulacc_level;
    level_t      o_addx_level;
    level_t      o_uram_index;
    int          error_count;
    logic [31:0] rng_job;
    logic [31:0] rng_busy;
    stage_mask_t start_s;
    logic        done_s;
    logic        idle_s;
    int          busy_left [NS];

    mvp_controller u_dut (.*);

    mvp_checker u_checker
    (
        .*,
        .i_stage_start  (o_stage_start),
        .i_mvp_done     (o_mvp_done),
        .i_mvp_idle     (o_mvp_idle),
        .i_stage_cnt    (o_stage_cnt),
        .i_reduce_trace (o_reduce_trace),
        .i_switch_mode  (o_switch_mode),
        .i_last_write   (o_last_write),
        .i_mux_level    (o_mux_level),
        .i_mulacc_level (o_mulacc_level),
        .i_addx_level   (o_addx_level),
        .i_uram_index   (o_uram_index),
        .o_error_count  (error_count)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw(inout logic [31:0] state, input int range, output int value);
        state = lcg_step(state);
        value = int'(state[30:16]) % range;
    endtask

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(negedge clk)
    begin
        start_s = o_stage_start;
        done_s  = o_mvp_done;
        idle_s  = o_mvp_idle;
    end

    // stage responders, done drops for a random busy time after a start
    always @(posedge clk)
    begin : responders
        int b;
        for (int k = 0; k < NS; k++)
        begin
            if (start_s[k])
            begin
                draw(rng_busy, 5, b);
                busy_left[k] = b;
            end
            else if (busy_left[k] != 0)
                busy_left[k] = busy_left[k] - 1;
            i_stage_done[k] <= (busy_left[k] == 0);
        end
    end

    task automatic run_job();
        int   level_pick;
        int   skip_pick;
        int   feed_rounds;
        int   fed;
        int   cycles;
        logic finished;

        // half the jobs use reduce level 1, the rest any level
        draw(rng_job, 24, level_pick);
        level_pick = (level_pick < 12) ? 1 : level_pick - 11;
        draw(rng_job, 2, skip_pick);
        draw(rng_job, 6, feed_rounds);
        feed_rounds = feed_rounds + 1;

        // start without enable, must be ignored
        @(posedge clk);
        i_enable    <= 1'b0;
        i_mvp_start <= 1'b1;
        @(posedge clk);
        i_enable       <= 1'b1;
        i_reduce_level <= level_t'(level_pick);
        i_skip_trace   <= skip_pick[0];
        i_feed_alldone <= 1'b0;
        @(posedge clk);
        i_mvp_start <= 1'b0;
        fed      = 0;
        cycles   = 0;
        finished = 1'b0;
        // unfinished jobs are restarted by the next job start
        while (!finished && cycles < CYCLE_LIMIT)
        begin
            @(posedge clk);
            if (start_s[0])
            begin
                fed = fed + 1;
                if (fed >= feed_rounds)
                    i_feed_alldone <= 1'b1;
            end
            cycles   = cycles + 1;
            finished = done_s;
        end
        i_feed_alldone <= 1'b1;
        while (finished && !idle_s)
            @(posedge clk);
    endtask

    initial
    begin
        rst_n          = 1'b0;
        i_mvp_start    = 1'b0;
        i_enable       = 1'b0;
        i_skip_trace   = 1'b0;
        i_reduce_level = '0;
        i_stage_done   = '1;
        i_feed_alldone = 1'b1;
        start_s        = '0;
        done_s         = 1'b0;
        idle_s         = 1'b1;
        rng_job        = 32'hb7b5;
        rng_busy       = ~32'hb7b5;
        for (int k = 0; k < NS; k++)
            busy_left[k] = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int job = 0; job < NUM_JOBS; job++)
            run_job();
        repeat (10) @(posedge clk);
        u_checker.print_counts();
        if (error_count == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t, the jobs did not complete in time", $time);
        u_checker.print_counts();
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+hdl
hdl/mvp_seq_pkg.sv
hdl/mvp_round_ctrl.sv
hdl/mvp_stage_tracker.sv
hdl/mvp_level_pipe.sv
hdl/mvp_controller.sv
verif/mvp_checker.sv
verif/tb_mvp_controller.sv
